// ==== list.f ====
rtl/procyon_types.sv
rtl/dcache_d0.sv
rtl/cache.sv
rtl/dcache_d1.sv
rtl/dcache.sv
tb/dcache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the data cache testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    --top-module dcache_tb -f list.f -o dcache_sim

# The simulator exits non-zero on a fatal check; the log decides the result
./obj_dir/dcache_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation completed successfully" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// ==== tb/dcache_tb.sv ====
// Data cache testbench: clock, reset, LFSR stimulus, reference cache model and result checks
`timescale 1ns/1ps

module dcache_tb;

    // Expected result of one request and the cycle count at which it is due
    typedef struct packed {
        logic [31:0]                        due;
        procyon_types::procyon_dc_op_t      op;
        logic                               hit;
        procyon_types::procyon_data_t       word;
        logic                               vvalid;
        logic                               vdirty;
        procyon_types::procyon_addr_t       vaddr;
        procyon_types::procyon_cacheline_t  vdata;
    } exp_t;

    logic                                   clk = 1'b0;
    logic                                   i_rst;
    logic                                   i_dc_wr_en;
    procyon_types::procyon_addr_t           i_dc_addr;
    procyon_types::procyon_data_t           i_dc_data;
    logic                                   i_dc_valid;
    logic                                   i_dc_dirty;
    logic                                   i_dc_fill;
    procyon_types::procyon_cacheline_t      i_dc_fill_data;
    logic                                   o_dc_hit;
    procyon_types::procyon_data_t           o_dc_data;
    logic                                   o_dc_victim_valid;
    logic                                   o_dc_victim_dirty;
    procyon_types::procyon_addr_t           o_dc_victim_addr;
    procyon_types::procyon_cacheline_t      o_dc_victim_data;

    // Reference model of the array contents
    logic                                   ref_valid [procyon_types::DC_NUM_LINES];
    logic                                   ref_dirty [procyon_types::DC_NUM_LINES];
    procyon_types::procyon_dc_tag_t         ref_tag   [procyon_types::DC_NUM_LINES];
    procyon_types::procyon_cacheline_t      ref_line  [procyon_types::DC_NUM_LINES];

    exp_t                                   exp_q [$];
    exp_t                                   cmp_e;
    logic [31:0]                            cyc = '0;
    logic [15:0]                            lfsr = 16'd42;
    int                                     err_count = 0;
    int                                     num_checked = 0;

    dcache dut_i (
        .clk(clk), .i_rst(i_rst),
        .i_dc_wr_en(i_dc_wr_en), .i_dc_addr(i_dc_addr), .i_dc_data(i_dc_data),
        .i_dc_valid(i_dc_valid), .i_dc_dirty(i_dc_dirty),
        .i_dc_fill(i_dc_fill), .i_dc_fill_data(i_dc_fill_data),
        .o_dc_hit(o_dc_hit), .o_dc_data(o_dc_data),
        .o_dc_victim_valid(o_dc_victim_valid), .o_dc_victim_dirty(o_dc_victim_dirty),
        .o_dc_victim_addr(o_dc_victim_addr), .o_dc_victim_data(o_dc_victim_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[126:0], next_bit()};
        end
        return r;
    endfunction

    // Applies one request to the model and returns what the DUT must report for it
    function automatic void ref_access(input procyon_types::procyon_dc_op_t op,
                                       input procyon_types::procyon_addr_t addr,
                                       input procyon_types::procyon_data_t data,
                                       input procyon_types::procyon_cacheline_t fill_line,
                                       input logic fvalid, input logic fdirty,
                                       output exp_t e);
        procyon_types::procyon_dc_tag_t     tag;
        procyon_types::procyon_dc_index_t   idx;
        procyon_types::procyon_cacheline_t  line;
        int                                 wi;
        tag  = addr[procyon_types::ADDR_WIDTH-1 -: procyon_types::DC_TAG_WIDTH];
        idx  = addr[procyon_types::DC_OFFSET_WIDTH +: procyon_types::DC_INDEX_WIDTH];
        wi   = int'(addr[3:2]);
        line = ref_line[idx];
        e        = '0;
        e.op     = op;
        e.hit    = ref_valid[idx] && (ref_tag[idx] == tag);
        e.word   = e.hit ? line[wi*procyon_types::DATA_WIDTH +: procyon_types::DATA_WIDTH] : '0;
        e.vvalid = ref_valid[idx];
        e.vdirty = ref_dirty[idx];
        e.vaddr  = {ref_tag[idx], idx, {procyon_types::DC_OFFSET_WIDTH{1'b0}}};
        e.vdata  = line;
        if (op == procyon_types::DC_OP_STORE && e.hit) begin
            line[wi*procyon_types::DATA_WIDTH +: procyon_types::DATA_WIDTH] = data;
            ref_line[idx]  = line;
            ref_dirty[idx] = 1'b1;
        end else if (op == procyon_types::DC_OP_FILL) begin
            ref_valid[idx] = fvalid;
            ref_dirty[idx] = fdirty;
            ref_tag[idx]   = tag;
            ref_line[idx]  = fill_line;
        end
    endfunction

    task automatic check_hit(input logic got, input logic exp);
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t: hit flag is %b, expected %b", $time, got, exp);
            $display("Simulation failed");
            $fatal(1, "hit flag mismatch");
        end
    endtask

    task automatic check_word(input procyon_types::procyon_data_t got,
                              input procyon_types::procyon_data_t exp);
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t: load word is %h, expected %h", $time, got, exp);
            $display("Simulation failed");
            $fatal(1, "load word mismatch");
        end
    endtask

    // Dirty bit, address and data of a victim only mean something when it is valid
    task automatic check_victim(input logic got_v, input logic got_d,
                                input procyon_types::procyon_addr_t got_a,
                                input procyon_types::procyon_cacheline_t got_l,
                                input logic exp_v, input logic exp_d,
                                input procyon_types::procyon_addr_t exp_a,
                                input procyon_types::procyon_cacheline_t exp_l);
        if (got_v !== exp_v || (exp_v && (got_d !== exp_d || got_a !== exp_a
                                          || got_l !== exp_l))) begin
            err_count++;
            $display("** Error at %0t: victim v=%b d=%b addr=%h data=%h",
                     $time, got_v, got_d, got_a, got_l);
            $display("expected victim v=%b d=%b addr=%h data=%h",
                     exp_v, exp_d, exp_a, exp_l);
            $display("Simulation failed");
            $fatal(1, "victim mismatch");
        end
    endtask

    // Results come out two edges after the request is sampled
    always @(negedge clk) begin
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            cmp_e = exp_q.pop_front();
            check_hit(o_dc_hit, cmp_e.hit);
            if (cmp_e.op == procyon_types::DC_OP_LOAD) begin
                check_word(o_dc_data, cmp_e.word);
            end
            check_victim(o_dc_victim_valid, o_dc_victim_dirty, o_dc_victim_addr,
                         o_dc_victim_data, cmp_e.vvalid, cmp_e.vdirty, cmp_e.vaddr,
                         cmp_e.vdata);
            num_checked++;
        end
    end

    task automatic issue(input procyon_types::procyon_dc_op_t op,
                         input procyon_types::procyon_addr_t addr,
                         input procyon_types::procyon_data_t data,
                         input procyon_types::procyon_cacheline_t fill_line,
                         input logic fvalid, input logic fdirty);
        exp_t e;
        @(posedge clk);
        i_dc_addr      <= addr;
        i_dc_wr_en     <= (op == procyon_types::DC_OP_STORE);
        i_dc_fill      <= (op == procyon_types::DC_OP_FILL);
        i_dc_data      <= data;
        i_dc_fill_data <= fill_line;
        i_dc_valid     <= fvalid;
        i_dc_dirty     <= fdirty;
        ref_access(op, addr, data, fill_line, fvalid, fdirty, e);
        e.due = cyc + 3;
        exp_q.push_back(e);
    endtask

    task automatic wait_results(input string phase);
        int n;
        n = 0;
        @(posedge clk);
        i_dc_wr_en <= 1'b0;
        i_dc_fill  <= 1'b0;
        while (exp_q.size() > 0 && n < 16) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() > 0) begin
            $display("Timed out waiting for the DUT results of the %s phase", phase);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    endtask

    initial begin
        logic [127:0]                       r;
        procyon_types::procyon_addr_t       base;
        procyon_types::procyon_addr_t       addr;
        procyon_types::procyon_cacheline_t  line;
        logic [6:0]                         op_sel;
        for (int i = 0; i < procyon_types::DC_NUM_LINES; i++) begin
            ref_valid[i] = 1'b0;
            ref_dirty[i] = 1'b0;
            ref_tag[i]   = '0;
            ref_line[i]  = '0;
        end
        i_rst          = 1'b1;
        i_dc_wr_en     = 1'b0;
        i_dc_fill      = 1'b0;
        i_dc_addr      = '0;
        i_dc_data      = '0;
        i_dc_valid     = 1'b0;
        i_dc_dirty     = 1'b0;
        i_dc_fill_data = '0;
        repeat (8) @(posedge clk);
        i_rst <= 1'b0;

        // An empty cache misses everywhere
        for (int i = 0; i < 8; i++) begin
            r = rand_bits(32);
            issue(procyon_types::DC_OP_LOAD, r[31:0], '0, '0, 1'b0, 1'b0);
        end
        wait_results("reset");

        // Fill a line, then read back each word
        base = {24'h00A5C3, 4'h3, 4'h0};
        line = rand_bits(128);
        issue(procyon_types::DC_OP_FILL, base, '0, line, 1'b1, 1'b0);
        for (int k = 0; k < 4; k++) begin
            issue(procyon_types::DC_OP_LOAD, base + 32'(4 * k), '0, '0, 1'b0, 1'b0);
        end
        wait_results("fill");

        // Store hit read back in the next cycle, then a store miss to the same index
        r = rand_bits(32);
        issue(procyon_types::DC_OP_STORE, base + 32'd8, r[31:0], '0, 1'b0, 1'b0);
        issue(procyon_types::DC_OP_LOAD, base + 32'd8, '0, '0, 1'b0, 1'b0);
        r = rand_bits(32);
        issue(procyon_types::DC_OP_STORE, {24'h0BEEF0, 4'h3, 4'h4}, r[31:0], '0, 1'b0, 1'b0);
        issue(procyon_types::DC_OP_LOAD, base + 32'd4, '0, '0, 1'b0, 1'b0);
        issue(procyon_types::DC_OP_LOAD, {24'h0BEEF0, 4'h3, 4'h4}, '0, '0, 1'b0, 1'b0);
        wait_results("store");

        // Evict a dirty line whose word 1 was stored after the fill
        base = {24'h001234, 4'h9, 4'h0};
        line = rand_bits(128);
        issue(procyon_types::DC_OP_FILL, base, '0, line, 1'b1, 1'b1);
        r = rand_bits(32);
        issue(procyon_types::DC_OP_STORE, base + 32'd4, r[31:0], '0, 1'b0, 1'b0);
        line = rand_bits(128);
        issue(procyon_types::DC_OP_FILL, {24'h00ABCD, 4'h9, 4'h0}, '0, line, 1'b1, 1'b0);
        issue(procyon_types::DC_OP_LOAD, base + 32'd4, '0, '0, 1'b0, 1'b0);
        issue(procyon_types::DC_OP_LOAD, {24'h00ABCD, 4'h9, 4'hC}, '0, '0, 1'b0, 1'b0);
        wait_results("eviction");

        // Random traffic over four tags keeps lines conflicting
        for (int i = 0; i < 2000; i++) begin
            r = rand_bits(10);
            addr = {22'h16A5A5, r[1:0], r[5:2], r[9:6]};
            r = rand_bits(7);
            op_sel = r[6:0];
            if (op_sel < 7'd64) begin
                issue(procyon_types::DC_OP_LOAD, addr, '0, '0, 1'b0, 1'b0);
            end else if (op_sel < 7'd102) begin
                r = rand_bits(32);
                issue(procyon_types::DC_OP_STORE, addr, r[31:0], '0, 1'b0, 1'b0);
            end else begin
                line = rand_bits(128);
                r = rand_bits(2);
                issue(procyon_types::DC_OP_FILL, addr, '0, line, r[0], r[1]);
            end
        end
        wait_results("random");

        $display("Checked %0d results", num_checked);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== rtl/dcache.sv ====
// Data cache top level: address split and stage 0, array and stage 1 connections
`timescale 1ns/1ps

module dcache (
    input  logic                                clk,
    input  logic                                i_rst,

    input  logic                                i_dc_wr_en,
    input  procyon_types::procyon_addr_t        i_dc_addr,
    input  procyon_types::procyon_data_t        i_dc_data,
    input  logic                                i_dc_valid,
    input  logic                                i_dc_dirty,
    input  logic                                i_dc_fill,
    input  procyon_types::procyon_cacheline_t   i_dc_fill_data,

    output logic                                o_dc_hit,
    output procyon_types::procyon_data_t        o_dc_data,
    output logic                                o_dc_victim_valid,
    output logic                                o_dc_victim_dirty,
    output procyon_types::procyon_addr_t        o_dc_victim_addr,
    output procyon_types::procyon_cacheline_t   o_dc_victim_data
);

    procyon_types::procyon_dc_tag_t             dc_tag;
    procyon_types::procyon_dc_index_t           dc_index;
    procyon_types::procyon_dc_offset_t          dc_offset;

    procyon_types::procyon_dc_op_t              d0_op;
    procyon_types::procyon_dc_tag_t             d0_tag;
    procyon_types::procyon_dc_index_t           d0_index;
    procyon_types::procyon_dc_offset_t          d0_offset;
    procyon_types::procyon_data_t               d0_data;
    logic                                       d0_valid;
    logic                                       d0_dirty;
    procyon_types::procyon_cacheline_t          d0_wr_line;

    logic                                       cache_rd_valid;
    logic                                       cache_rd_dirty;
    procyon_types::procyon_dc_tag_t             cache_rd_tag;
    procyon_types::procyon_cacheline_t          cache_rd_data;

    logic                                       cache_wr_en;
    procyon_types::procyon_dc_index_t           cache_wr_index;
    logic                                       cache_wr_valid;
    logic                                       cache_wr_dirty;
    procyon_types::procyon_dc_tag_t             cache_wr_tag;
    procyon_types::procyon_cacheline_t          cache_wr_data;

    // Split the request address into tag, line index and byte offset
    assign dc_tag    = i_dc_addr[procyon_types::ADDR_WIDTH-1 -: procyon_types::DC_TAG_WIDTH];
    assign dc_index  = i_dc_addr[procyon_types::DC_OFFSET_WIDTH +: procyon_types::DC_INDEX_WIDTH];
    assign dc_offset = i_dc_addr[procyon_types::DC_OFFSET_WIDTH-1:0];

    dcache_d0 dcache_d0_inst (
        .clk(clk), .i_rst(i_rst),
        .i_wr_en(i_dc_wr_en), .i_fill(i_dc_fill),
        .i_tag(dc_tag), .i_index(dc_index), .i_offset(dc_offset),
        .i_data(i_dc_data), .i_valid(i_dc_valid), .i_dirty(i_dc_dirty),
        .i_fill_data(i_dc_fill_data),
        .o_op(d0_op), .o_tag(d0_tag), .o_index(d0_index), .o_offset(d0_offset),
        .o_data(d0_data), .o_valid(d0_valid), .o_dirty(d0_dirty),
        .o_wr_line(d0_wr_line)
    );

    // The array read is registered, so it is indexed straight from the
    // request and lines up with the stage 0 register
    cache data_cache_inst (
        .clk(clk), .i_rst(i_rst),
        .i_cache_wr_en(cache_wr_en), .i_cache_wr_index(cache_wr_index),
        .i_cache_wr_valid(cache_wr_valid), .i_cache_wr_dirty(cache_wr_dirty),
        .i_cache_wr_tag(cache_wr_tag), .i_cache_wr_data(cache_wr_data),
        .i_cache_rd_index(dc_index),
        .o_cache_rd_valid(cache_rd_valid), .o_cache_rd_dirty(cache_rd_dirty),
        .o_cache_rd_tag(cache_rd_tag), .o_cache_rd_data(cache_rd_data)
    );

    dcache_d1 dcache_d1_inst (
        .clk(clk), .i_rst(i_rst),
        .i_op(d0_op), .i_tag(d0_tag), .i_index(d0_index), .i_offset(d0_offset),
        .i_data(d0_data), .i_valid(d0_valid), .i_dirty(d0_dirty),
        .i_wr_line(d0_wr_line),
        .i_cache_rd_valid(cache_rd_valid), .i_cache_rd_dirty(cache_rd_dirty),
        .i_cache_rd_tag(cache_rd_tag), .i_cache_rd_data(cache_rd_data),
        .o_cache_wr_en(cache_wr_en), .o_cache_wr_index(cache_wr_index),
        .o_cache_wr_valid(cache_wr_valid), .o_cache_wr_dirty(cache_wr_dirty),
        .o_cache_wr_tag(cache_wr_tag), .o_cache_wr_data(cache_wr_data),
        .o_hit(o_dc_hit), .o_data(o_dc_data),
        .o_victim_valid(o_dc_victim_valid), .o_victim_dirty(o_dc_victim_dirty),
        .o_victim_addr(o_dc_victim_addr), .o_victim_data(o_dc_victim_data)
    );

endmodule

// ==== rtl/dcache_d1.sv ====
// Data cache stage 1: write bypass, tag compare, load word select, array write and victim
`timescale 1ns/1ps

module dcache_d1 (
    input  logic                                clk,
    input  logic                                i_rst,

    input  procyon_types::procyon_dc_op_t       i_op,
    input  procyon_types::procyon_dc_tag_t      i_tag,
    input  procyon_types::procyon_dc_index_t    i_index,
    input  procyon_types::procyon_dc_offset_t   i_offset,
    input  procyon_types::procyon_data_t        i_data,
    input  logic                                i_valid,
    input  logic                                i_dirty,
    input  procyon_types::procyon_cacheline_t   i_wr_line,

    input  logic                                i_cache_rd_valid,
    input  logic                                i_cache_rd_dirty,
    input  procyon_types::procyon_dc_tag_t      i_cache_rd_tag,
    input  procyon_types::procyon_cacheline_t   i_cache_rd_data,

    output logic                                o_cache_wr_en,
    output procyon_types::procyon_dc_index_t    o_cache_wr_index,
    output logic                                o_cache_wr_valid,
    output logic                                o_cache_wr_dirty,
    output procyon_types::procyon_dc_tag_t      o_cache_wr_tag,
    output procyon_types::procyon_cacheline_t   o_cache_wr_data,

    output logic                                o_hit,
    output procyon_types::procyon_data_t        o_data,
    output logic                                o_victim_valid,
    output logic                                o_victim_dirty,
    output procyon_types::procyon_addr_t        o_victim_addr,
    output procyon_types::procyon_cacheline_t   o_victim_data
);

    // Copy of the array write issued last cycle
    logic                                       byp_en;
    procyon_types::procyon_dc_index_t           byp_index;
    logic                                       byp_valid;
    logic                                       byp_dirty;
    procyon_types::procyon_dc_tag_t             byp_tag;
    procyon_types::procyon_cacheline_t          byp_data;
    logic                                       byp_match;

    // Current contents of the indexed line, after the bypass
    logic                                       line_valid;
    logic                                       line_dirty;
    procyon_types::procyon_dc_tag_t             line_tag;
    procyon_types::procyon_cacheline_t          line_data;

    logic                                       hit;
    logic [procyon_types::DC_WORD_SEL_WIDTH-1:0] word_sel;
    procyon_types::procyon_data_t               sel_word;
    procyon_types::procyon_data_t               rd_word;
    procyon_types::procyon_cacheline_t          word_mask;
    procyon_types::procyon_cacheline_t          merged_line;

    assign word_sel = i_offset[procyon_types::DC_OFFSET_WIDTH-1:
                               procyon_types::DC_BYTE_SEL_WIDTH];

    // The array read for this request was taken while last cycle's write was
    // still pending, so that write is forwarded when the index matches
    assign byp_match  = byp_en && (byp_index == i_index);
    assign line_valid = byp_match ? byp_valid : i_cache_rd_valid;
    assign line_dirty = byp_match ? byp_dirty : i_cache_rd_dirty;
    assign line_tag   = byp_match ? byp_tag   : i_cache_rd_tag;
    assign line_data  = byp_match ? byp_data  : i_cache_rd_data;

    assign hit = line_valid && (line_tag == i_tag);

    always_comb begin
        sel_word  = '0;
        word_mask = '0;
        for (int k = 0; k < procyon_types::DC_WORDS; k++) begin
            if (int'(word_sel) == k) begin
                sel_word = line_data[k*procyon_types::DATA_WIDTH +: procyon_types::DATA_WIDTH];
                word_mask[k*procyon_types::DATA_WIDTH +: procyon_types::DATA_WIDTH] = '1;
            end
        end
    end

    assign merged_line = (line_data & ~word_mask) | (i_wr_line & word_mask);

    // On a store the addressed word reads back as the value just written
    assign rd_word = (i_op == procyon_types::DC_OP_STORE) ? i_data : sel_word;

    always_comb begin
        o_cache_wr_en    = 1'b0;
        o_cache_wr_index = i_index;
        o_cache_wr_valid = line_valid;
        o_cache_wr_dirty = line_dirty;
        o_cache_wr_tag   = line_tag;
        o_cache_wr_data  = line_data;
        case (i_op)
            procyon_types::DC_OP_STORE: begin
                // Stores that miss leave the array alone
                o_cache_wr_en    = hit;
                o_cache_wr_dirty = 1'b1;
                o_cache_wr_data  = merged_line;
            end
            procyon_types::DC_OP_FILL: begin
                o_cache_wr_en    = 1'b1;
                o_cache_wr_valid = i_valid;
                o_cache_wr_dirty = i_dirty;
                o_cache_wr_tag   = i_tag;
                o_cache_wr_data  = i_wr_line;
            end
            default: begin
                o_cache_wr_en    = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            byp_en         <= 1'b0;
            o_hit          <= 1'b0;
            o_victim_valid <= 1'b0;
        end else begin
            byp_en         <= o_cache_wr_en;
            o_hit          <= hit;
            o_victim_valid <= line_valid;
        end
    end

    always_ff @(posedge clk) begin
        byp_index      <= o_cache_wr_index;
        byp_valid      <= o_cache_wr_valid;
        byp_dirty      <= o_cache_wr_dirty;
        byp_tag        <= o_cache_wr_tag;
        byp_data       <= o_cache_wr_data;
        o_data         <= hit ? rd_word : '0;
        o_victim_dirty <= line_dirty;
        o_victim_addr  <= {line_tag, i_index, {procyon_types::DC_OFFSET_WIDTH{1'b0}}};
        o_victim_data  <= line_data;
    end

endmodule

// ==== rtl/cache.sv ====
// Direct mapped line storage with per-line valid, dirty, tag and data
`timescale 1ns/1ps

module cache (
    input  logic                                clk,
    input  logic                                i_rst,

    input  logic                                i_cache_wr_en,
    input  procyon_types::procyon_dc_index_t    i_cache_wr_index,
    input  logic                                i_cache_wr_valid,
    input  logic                                i_cache_wr_dirty,
    input  procyon_types::procyon_dc_tag_t      i_cache_wr_tag,
    input  procyon_types::procyon_cacheline_t   i_cache_wr_data,

    input  procyon_types::procyon_dc_index_t    i_cache_rd_index,
    output logic                                o_cache_rd_valid,
    output logic                                o_cache_rd_dirty,
    output procyon_types::procyon_dc_tag_t      o_cache_rd_tag,
    output procyon_types::procyon_cacheline_t   o_cache_rd_data
);

    logic                                       line_valid [procyon_types::DC_NUM_LINES];
    logic                                       line_dirty [procyon_types::DC_NUM_LINES];
    procyon_types::procyon_dc_tag_t             line_tag   [procyon_types::DC_NUM_LINES];
    procyon_types::procyon_cacheline_t          line_data  [procyon_types::DC_NUM_LINES];

    // Only the valid bits need clearing for the array to start out empty
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < procyon_types::DC_NUM_LINES; i++) begin
                line_valid[i] <= 1'b0;
            end
        end else if (i_cache_wr_en) begin
            line_valid[i_cache_wr_index] <= i_cache_wr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_cache_wr_en) begin
            line_dirty[i_cache_wr_index] <= i_cache_wr_dirty;
            line_tag[i_cache_wr_index]   <= i_cache_wr_tag;
            line_data[i_cache_wr_index]  <= i_cache_wr_data;
        end
    end

    // The array is read every cycle. A write to the same index in the same
    // cycle is not seen here; stage 1 bypasses around that case
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_cache_rd_valid <= 1'b0;
        end else begin
            o_cache_rd_valid <= line_valid[i_cache_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        o_cache_rd_dirty <= line_dirty[i_cache_rd_index];
        o_cache_rd_tag   <= line_tag[i_cache_rd_index];
        o_cache_rd_data  <= line_data[i_cache_rd_index];
    end

endmodule

// ==== rtl/dcache_d0.sv ====
// Data cache stage 0: request register, opcode encoding and write line formation
`timescale 1ns/1ps

module dcache_d0 (
    input  logic                                clk,
    input  logic                                i_rst,

    input  logic                                i_wr_en,
    input  logic                                i_fill,
    input  procyon_types::procyon_dc_tag_t      i_tag,
    input  procyon_types::procyon_dc_index_t    i_index,
    input  procyon_types::procyon_dc_offset_t   i_offset,
    input  procyon_types::procyon_data_t        i_data,
    input  logic                                i_valid,
    input  logic                                i_dirty,
    input  procyon_types::procyon_cacheline_t   i_fill_data,

    output procyon_types::procyon_dc_op_t       o_op,
    output procyon_types::procyon_dc_tag_t      o_tag,
    output procyon_types::procyon_dc_index_t    o_index,
    output procyon_types::procyon_dc_offset_t   o_offset,
    output procyon_types::procyon_data_t        o_data,
    output logic                                o_valid,
    output logic                                o_dirty,
    output procyon_types::procyon_cacheline_t   o_wr_line
);

    procyon_types::procyon_dc_op_t              op;
    procyon_types::procyon_cacheline_t          wr_line;
    logic [procyon_types::DC_WORD_SEL_WIDTH-1:0] word_sel;

    assign word_sel = i_offset[procyon_types::DC_OFFSET_WIDTH-1:
                               procyon_types::DC_BYTE_SEL_WIDTH];

    // A fill wins over a store; with neither strobe set the request is a load
    always_comb begin
        if (i_fill) begin
            op = procyon_types::DC_OP_FILL;
        end else if (i_wr_en) begin
            op = procyon_types::DC_OP_STORE;
        end else begin
            op = procyon_types::DC_OP_LOAD;
        end
    end

    // Fills carry their whole line; stores only place the word in its slot and
    // stage 1 merges it with the line read from the array
    always_comb begin
        wr_line = '0;
        if (i_fill) begin
            wr_line = i_fill_data;
        end else begin
            for (int k = 0; k < procyon_types::DC_WORDS; k++) begin
                if (int'(word_sel) == k) begin
                    wr_line[k*procyon_types::DATA_WIDTH +: procyon_types::DATA_WIDTH] = i_data;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_op <= procyon_types::DC_OP_LOAD;
        end else begin
            o_op <= op;
        end
    end

    always_ff @(posedge clk) begin
        o_tag     <= i_tag;
        o_index   <= i_index;
        o_offset  <= i_offset;
        o_data    <= i_data;
        o_valid   <= i_valid;
        o_dirty   <= i_dirty;
        o_wr_line <= wr_line;
    end

endmodule

// ==== rtl/procyon_types.sv ====
// Data cache geometry, address and cache line types, and the cache opcode enum
package procyon_types;

    // Processor word and address widths
    localparam int ADDR_WIDTH         = 32;
    localparam int DATA_WIDTH         = 32;

    // Data cache geometry in bytes
    localparam int DC_LINE_SIZE       = 16;
    localparam int DC_CACHE_SIZE      = 256;
    localparam int DC_NUM_LINES       = DC_CACHE_SIZE / DC_LINE_SIZE;

    // Address split into tag, index and byte offset
    localparam int DC_OFFSET_WIDTH    = $clog2(DC_LINE_SIZE);
    localparam int DC_INDEX_WIDTH     = $clog2(DC_NUM_LINES);
    localparam int DC_TAG_WIDTH       = ADDR_WIDTH - DC_INDEX_WIDTH - DC_OFFSET_WIDTH;

    // Words per line; the upper offset bits pick the word, the lower ones the byte
    localparam int DC_WORDS           = DC_LINE_SIZE / (DATA_WIDTH / 8);
    localparam int DC_BYTE_SEL_WIDTH  = $clog2(DATA_WIDTH / 8);
    localparam int DC_WORD_SEL_WIDTH  = $clog2(DC_WORDS);

    typedef logic [ADDR_WIDTH-1:0]        procyon_addr_t;
    typedef logic [DATA_WIDTH-1:0]        procyon_data_t;

    // Word k of a line sits at bits DATA_WIDTH*k and up
    typedef logic [DC_LINE_SIZE*8-1:0]    procyon_cacheline_t;

    typedef logic [DC_TAG_WIDTH-1:0]      procyon_dc_tag_t;
    typedef logic [DC_INDEX_WIDTH-1:0]    procyon_dc_index_t;
    typedef logic [DC_OFFSET_WIDTH-1:0]   procyon_dc_offset_t;

    // Request type carried from stage 0 to stage 1
    typedef enum logic [1:0] {
        DC_OP_LOAD  = 2'b00,
        DC_OP_STORE = 2'b01,
        DC_OP_FILL  = 2'b10
    } procyon_dc_op_t;

endpackage
